//--- rtl/cpu_defs.svh
// shared sizes for the two-core memory subsystem
// include in any file that needs a width, the ram depth or its latency

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data word bits
`define WORD_W 32
// word address bits
`define ADDR_W 8
// words held by the ram
`define RAM_DEPTH 256
// cycles from request to ACCESS
`define RAM_LAT 3
// cores on the bus, controller is built for two
`define CPUS 2

`endif

//--- rtl/cpu_types_pkg.sv
// types shared by the controller, the ram model and both interfaces
// import wherever a word, an address or a state is declared

`include "cpu_defs.svh"

package cpu_types_pkg;

   typedef logic [`WORD_W-1:0] word_t;   // one data word
   typedef logic [`ADDR_W-1:0] addr_t;   // word address

   // ram status, decoded every cycle
   typedef enum logic [1:0] {
      FREE,     // no request
      BUSY,     // latency running
      ACCESS,   // data valid or write lands
      ERROR     // address past the end
   } ramstate_t;

   // coherence controller states, digit is the requesting core
   typedef enum logic [2:0] {
      IDLE, SNOOP0, SNOOP1, CACHE0, CACHE1, MEM0, MEM1
   } cc_state_t;

endpackage

//--- rtl/cache_control_if.sv
// per-core bus between the two caches and the coherence controller
// every signal is an array with one entry per core
// the controller takes modport ctrl, the cache side is modport cache

`timescale 1ns/100ps
`include "cpu_defs.svh"

interface cache_control_if;
   import cpu_types_pkg::*;

   // instruction port
   logic  [`CPUS-1:0] iREN;
   addr_t [`CPUS-1:0] iaddr;
   logic  [`CPUS-1:0] iwait;
   word_t [`CPUS-1:0] iload;    // raw ram data, valid while iwait low

   // data port
   logic  [`CPUS-1:0] dREN;
   logic  [`CPUS-1:0] dWEN;
   addr_t [`CPUS-1:0] daddr;
   word_t [`CPUS-1:0] dstore;
   logic  [`CPUS-1:0] dwait;
   word_t [`CPUS-1:0] dload;

   // coherence
   logic  [`CPUS-1:0] ccwrite;      // cache holds line modified, or writes with invalidate
   logic  [`CPUS-1:0] cctrans;      // closes the open data transaction
   logic  [`CPUS-1:0] ccwait;       // core is being snooped
   logic  [`CPUS-1:0] ccinv;        // drop the line at ccsnoopaddr
   addr_t [`CPUS-1:0] ccsnoopaddr;  // address to look up in the snoop tags

   modport ctrl (
      input  iREN, iaddr,
      input  dREN, dWEN, daddr, dstore,
      input  ccwrite, cctrans,
      output iwait, iload,
      output dwait, dload,
      output ccwait, ccinv, ccsnoopaddr
   );

   modport cache (
      output iREN, iaddr,
      output dREN, dWEN, daddr, dstore,
      output ccwrite, cctrans,
      input  iwait, iload,
      input  dwait, dload,
      input  ccwait, ccinv, ccsnoopaddr
   );

endinterface

//--- rtl/ram_if.sv
// single ram port between the coherence controller and the ram model
// controller takes modport ctrl, the ram takes modport mem

`timescale 1ns/100ps

interface ram_if;
   import cpu_types_pkg::*;

   logic      ramREN;
   logic      ramWEN;
   addr_t     ramaddr;
   word_t     ramstore;
   word_t     ramload;    // only meaningful in ACCESS
   ramstate_t ramstate;

   modport ctrl (
      output ramREN,
      output ramWEN,
      output ramaddr,
      output ramstore,
      input  ramload,
      input  ramstate
   );

   modport mem (
      input  ramREN,
      input  ramWEN,
      input  ramaddr,
      input  ramstore,
      output ramload,
      output ramstate
   );

endinterface

//--- rtl/memory_control.sv
// coherence controller and ram arbiter for two snooping cores
// a data request snoops the other core, then goes cache to cache or to ram
// instruction fetches use the ram only in IDLE, core 0 first
// all outputs are combinational from the registered state

`timescale 1ns/100ps

module memory_control (
   input logic           CLK,
   input logic           nRST,
   cache_control_if.ctrl ccif,
   ram_if.ctrl           ramif
);
   import cpu_types_pkg::*;

   cc_state_t   state, next_state;
   addr_t [1:0] snoop_q;    // snoop address held per target core
   logic        req;        // core that owns the open transaction
   logic        oth;        // the core being snooped
   logic        snooping;
   logic        ram_done;

   assign req      = (state == SNOOP1) || (state == CACHE1) || (state == MEM1);
   assign oth      = !req;
   assign snooping = (state == SNOOP0) || (state == SNOOP1);
   assign ram_done = (ramif.ramstate == ACCESS);  // word done this cycle

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   // hold-over for the snooped address, so it stays put once idle
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         snoop_q <= '0;
      end else if (snooping) begin
         snoop_q[oth] <= ccif.daddr[req];
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (ccif.dREN[0] || ccif.dWEN[0]) begin  // core 0 first
               next_state = SNOOP0;
            end else if (ccif.dREN[1] || ccif.dWEN[1]) begin
               next_state = SNOOP1;
            end
         end
         SNOOP0: next_state = ccif.ccwrite[1] ? CACHE0 : MEM0;
         SNOOP1: next_state = ccif.ccwrite[0] ? CACHE1 : MEM1;
         CACHE0, CACHE1: begin
            // done once the owner leaves M, or it moved to another line
            if (!ccif.ccwrite[oth] || (ccif.daddr[0] != ccif.daddr[1])) begin
               next_state = IDLE;
            end
         end
         MEM0, MEM1: begin
            if (ccif.cctrans[req]) begin
               next_state = IDLE;
            end
         end
         default: next_state = IDLE;
      endcase
   end

   // iload is the ram bus itself, the core qualifies it with iwait
   assign ccif.iload[0] = ramif.ramload;
   assign ccif.iload[1] = ramif.ramload;

   always_comb begin
      // nothing granted, ram idle
      ramif.ramREN     = 1'b0;
      ramif.ramWEN     = 1'b0;
      ramif.ramaddr    = ccif.iaddr[0];
      ramif.ramstore   = '0;
      ccif.iwait       = '1;
      ccif.dwait       = '1;
      ccif.dload[0]    = ramif.ramload;
      ccif.dload[1]    = ramif.ramload;
      ccif.ccwait      = '0;
      ccif.ccinv       = '0;
      ccif.ccsnoopaddr = snoop_q;
      case (state)
         IDLE: begin
            if (ccif.iREN[0]) begin
               ramif.ramREN  = 1'b1;
               ramif.ramaddr = ccif.iaddr[0];
               ccif.iwait[0] = !ram_done;
            end else if (ccif.iREN[1]) begin
               ramif.ramREN  = 1'b1;
               ramif.ramaddr = ccif.iaddr[1];
               ccif.iwait[1] = !ram_done;
            end
         end
         SNOOP0, SNOOP1: begin
            ccif.ccwait[oth]      = 1'b1;             // freeze the other core
            ccif.ccsnoopaddr[oth] = ccif.daddr[req];  // live address this cycle
            ccif.ccinv[oth]       = ccif.ccwrite[req] & ccif.dWEN[req];
         end
         CACHE0, CACHE1: begin
            ccif.ccwait[oth] = 1'b1;
            // requester gets the owner's word straight away
            ccif.dload[req]  = ccif.dstore[oth];
            ccif.dwait[req]  = 1'b0;
            // owner's word goes back to ram in parallel
            ramif.ramWEN     = ccif.dWEN[oth];
            ramif.ramaddr    = ccif.daddr[oth];
            ramif.ramstore   = ccif.dstore[oth];
            ccif.dwait[oth]  = !ram_done;  // owner waits for the write to land
         end
         MEM0, MEM1: begin
            ramif.ramWEN    = ccif.dWEN[req];
            ramif.ramREN    = ccif.dREN[req] & !ccif.dWEN[req];  // write wins
            ramif.ramaddr   = ccif.daddr[req];
            ramif.ramstore  = ccif.dstore[req];
            ccif.dwait[req] = !ram_done;
         end
         default: ;
      endcase
   end

   a_ram_one_op: assert property (@(posedge CLK) disable iff (!nRST)
      !(ramif.ramREN && ramif.ramWEN));

   // one fetch at a time, whatever the cores request
   a_one_fetch: assert property (@(posedge CLK) disable iff (!nRST)
      |ccif.iwait);

   // ram ownership ends only on cctrans
   a_mem_hold: assert property (@(posedge CLK) disable iff (!nRST)
      ((state == MEM0) && !ccif.cctrans[0]) || ((state == MEM1) && !ccif.cctrans[1])
      |=> state == $past(state));

endmodule

//--- rtl/ram.sv
// single-port word ram with a fixed access latency
// a held request shows BUSY for RAM_LAT-1 cycles, then ACCESS for one
// changing address or operation restarts the count, a held request repeats

`timescale 1ns/100ps
`include "cpu_defs.svh"

module ram (
   input logic CLK,
   input logic nRST,
   ram_if.mem  ramif
);
   import cpu_types_pkg::*;

   localparam int CNT_W = $clog2(`RAM_LAT + 1);
   localparam logic [CNT_W-1:0] LAST = CNT_W'(`RAM_LAT - 1);  // count of the ACCESS cycle

   word_t            mem [`RAM_DEPTH];
   logic [CNT_W-1:0] cnt;
   logic [CNT_W-1:0] cnt_eff;   // count seen this cycle
   addr_t            last_addr;
   logic             last_wen;
   logic             last_req;
   logic             req;
   logic             restart;
   logic             in_range;
   ramstate_t        state;

   assign req      = ramif.ramREN | ramif.ramWEN;
   assign in_range = (ramif.ramaddr < `RAM_DEPTH);
   // new access when the request appears or its address or op changes
   assign restart  = !last_req || (ramif.ramaddr != last_addr) || (ramif.ramWEN != last_wen);
   assign cnt_eff  = restart ? '0 : cnt;

   always_comb begin
      if (!req) begin
         state = FREE;
      end else if (!in_range) begin
         state = ERROR;
      end else if (cnt_eff == LAST) begin
         state = ACCESS;
      end else begin
         state = BUSY;
      end
   end

   assign ramif.ramstate = state;
   assign ramif.ramload  = (state == ACCESS) ? mem[ramif.ramaddr] : '0;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         cnt       <= '0;
         last_addr <= '0;
         last_wen  <= 1'b0;
         last_req  <= 1'b0;
      end else begin
         last_req  <= req;
         last_addr <= ramif.ramaddr;
         last_wen  <= ramif.ramWEN;
         if (!req || (cnt_eff == LAST)) begin
            cnt <= '0;  // idle, or wrap for the next access
         end else begin
            cnt <= cnt_eff + 1'b1;
         end
      end
   end

   // storage comes up all zero, write lands at the end of ACCESS
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < `RAM_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if ((state == ACCESS) && ramif.ramWEN) begin
         mem[ramif.ramaddr] <= ramif.ramstore;
      end
   end

   a_store_known: assert property (@(posedge CLK) disable iff (!nRST)
      ramif.ramWEN |-> !$isunknown(ramif.ramstore));

endmodule

//--- rtl/memory_subsystem.sv
// top level of the shared memory for two cores
// plain per-core ports, one array entry per core, go onto the controller bus
// controller and ram sit behind it with no extra cycles

`timescale 1ns/100ps
`include "cpu_defs.svh"

module memory_subsystem (
   input  logic                               CLK,
   input  logic                               nRST,
   // requests from the caches
   input  logic [`CPUS-1:0]                   iREN,
   input  cpu_types_pkg::addr_t [`CPUS-1:0]   iaddr,
   input  logic [`CPUS-1:0]                   dREN,
   input  logic [`CPUS-1:0]                   dWEN,
   input  cpu_types_pkg::addr_t [`CPUS-1:0]   daddr,
   input  cpu_types_pkg::word_t [`CPUS-1:0]   dstore,
   input  logic [`CPUS-1:0]                   ccwrite,
   input  logic [`CPUS-1:0]                   cctrans,
   // responses to the caches
   output logic [`CPUS-1:0]                   iwait,
   output cpu_types_pkg::word_t [`CPUS-1:0]   iload,
   output logic [`CPUS-1:0]                   dwait,
   output cpu_types_pkg::word_t [`CPUS-1:0]   dload,
   output logic [`CPUS-1:0]                   ccwait,
   output logic [`CPUS-1:0]                   ccinv,
   output cpu_types_pkg::addr_t [`CPUS-1:0]   ccsnoopaddr
);

   cache_control_if ccif ();
   ram_if           ramif ();

   // top plays the cache side of ccif
   assign ccif.iREN    = iREN;
   assign ccif.iaddr   = iaddr;
   assign ccif.dREN    = dREN;
   assign ccif.dWEN    = dWEN;
   assign ccif.daddr   = daddr;
   assign ccif.dstore  = dstore;
   assign ccif.ccwrite = ccwrite;
   assign ccif.cctrans = cctrans;

   assign iwait       = ccif.iwait;
   assign iload       = ccif.iload;
   assign dwait       = ccif.dwait;
   assign dload       = ccif.dload;
   assign ccwait      = ccif.ccwait;
   assign ccinv       = ccif.ccinv;
   assign ccsnoopaddr = ccif.ccsnoopaddr;

   memory_control i_ctrl (
      .CLK   (CLK),
      .nRST  (nRST),
      .ccif  (ccif.ctrl),
      .ramif (ramif.ctrl)
   );

   ram i_ram (
      .CLK   (CLK),
      .nRST  (nRST),
      .ramif (ramif.mem)
   );

endmodule

//--- test/tb_clock.sv
// clock and reset source for the memory subsystem testbench
// 20 ns period, reset low for the first three rising edges

`timescale 1ns/100ps

module tb_clock #(
   parameter int RST_CYCLES = 3
) (
   output logic CLK,
   output logic nRST
);
   localparam time HALF = 10ns;

   initial begin
      CLK = 1'b0;
      forever #HALF CLK = ~CLK;
   end

   initial begin
      #1;
      nRST = 1'b0;                // falls once all async resets are listening
      repeat (RST_CYCLES) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;                // released away from the rising edge
   end

endmodule

//--- test/tb_memory_subsystem.sv
// testbench for the two-core memory subsystem, plays both caches
// a shadow array tracks every completed write, assertions check the outputs
// each transaction type runs at least once and a watchdog ends a hung run

`timescale 1ns/100ps
`include "cpu_defs.svh"

module tb_memory_subsystem;
   import cpu_types_pkg::*;

   localparam int N_WR    = 8;                 // random writes in the ram test
   localparam int N_TRANS = 2 * N_WR + 7;      // every transaction of the run
   localparam int WD_CYCLES = N_TRANS * 40 * `RAM_LAT;

   logic CLK, nRST;
   logic  [`CPUS-1:0] iREN, dREN, dWEN, ccwrite, cctrans;
   addr_t [`CPUS-1:0] iaddr, daddr, ccsnoopaddr;
   word_t [`CPUS-1:0] dstore, iload, dload;
   logic  [`CPUS-1:0] iwait, dwait, ccwait, ccinv;
   word_t shadow [`RAM_DEPTH];                 // what the ram should hold
   logic [31:0] rng;
   int errors, tests_run, tests_failed;

   tb_clock i_clock (.CLK(CLK), .nRST(nRST));

   memory_subsystem i_dut (.*);

   // shadow follows every word whose write completed this cycle
   always @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < `RAM_DEPTH; i++) shadow[i] <= '0;
      end else begin
         for (int c = 0; c < `CPUS; c++)
            if (dWEN[c] && !dwait[c]) shadow[daddr[c]] <= dstore[c];
      end
   end

   for (genvar c = 0; c < `CPUS; c++) begin : g_core
      word_t exp_d, exp_i;
      assign exp_d = shadow[daddr[c]];
      assign exp_i = shadow[iaddr[c]];

      // ram read, other core not owning the line
      a_dload: assert property (@(posedge CLK) disable iff (!nRST)
         dREN[c] && !dWEN[c] && !dwait[c] && !ccwrite[1-c] |-> dload[c] == exp_d)
      else begin
         $display("CHECK FAILED dload[%0d] = %h, expected %h", c, $sampled(dload[c]),
                  $sampled(exp_d));
         errors++;
      end
      a_iload: assert property (@(posedge CLK) disable iff (!nRST)
         !iwait[c] |-> iload[c] == exp_i)
      else begin
         $display("CHECK FAILED iload[%0d] = %h, expected %h", c, $sampled(iload[c]),
                  $sampled(exp_i));
         errors++;
      end
      // held snoop address only moves while that core is snooped
      a_snoop_hold: assert property (@(posedge CLK) disable iff (!nRST)
         !ccwait[c] |-> $stable(ccsnoopaddr[c]))
      else begin
         $display("CHECK FAILED ccsnoopaddr[%0d] changed to %h while idle", c,
                  $sampled(ccsnoopaddr[c]));
         errors++;
      end
      a_inv_cause: assert property (@(posedge CLK) disable iff (!nRST)
         ccinv[c] |-> dWEN[1-c] && ccwrite[1-c])
      else begin
         $display("CHECK FAILED ccinv = %h with dWEN = %h, ccwrite = %h", $sampled(ccinv),
                  $sampled(dWEN), $sampled(ccwrite));
         errors++;
      end
   end

   a_fetch_order: assert property (@(posedge CLK) disable iff (!nRST)
      !iwait[1] |-> !iREN[0])
   else begin
      $display("CHECK FAILED iwait = %h while iREN = %h", $sampled(iwait), $sampled(iREN));
      errors++;
   end
   // idle to snoop in one cycle, live address to core 1
   a_snoop: assert property (@(posedge CLK) disable iff (!nRST)
      $rose(dREN[0] | dWEN[0]) |=> ccwait[1] && ccsnoopaddr[1] == $past(daddr[0]))
   else begin
      $display("CHECK FAILED ccwait = %h, ccsnoopaddr[1] = %h, expected %h", $sampled(ccwait),
               $sampled(ccsnoopaddr[1]), $sampled(daddr[0]));
      errors++;
   end
   a_inv: assert property (@(posedge CLK) disable iff (!nRST)
      ccwrite[0] && $rose(dWEN[0]) |=> ccinv[1])
   else begin
      $display("CHECK FAILED ccinv = %h in snoop of an invalidating write", $sampled(ccinv));
      errors++;
   end
   a_c2c: assert property (@(posedge CLK) disable iff (!nRST)
      dREN[0] && !dwait[0] && ccwrite[1] |-> dload[0] == dstore[1])
   else begin
      $display("CHECK FAILED dload[0] = %h, expected %h", $sampled(dload[0]),
               $sampled(dstore[1]));
      errors++;
   end
   // snoop address registers come out of reset cleared
   a_reset: assert property (@(posedge CLK)
      (!nRST || $rose(nRST)) |-> (&iwait) && (&dwait) && ccwait == '0 && ccinv == '0
         && ccsnoopaddr == '0)
   else begin
      $display("CHECK FAILED iwait = %h, dwait = %h, ccwait = %h, ccinv = %h at reset",
               $sampled(iwait), $sampled(dwait), $sampled(ccwait), $sampled(ccinv));
      $display("CHECK FAILED ccsnoopaddr = %h at reset, expected 0", $sampled(ccsnoopaddr));
      errors++;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   // called at a falling edge, returns at the falling edge after the done cycle
   task automatic wait_done(input bit instr, input int c);
      #1;
      while ((instr ? iwait[c] : dwait[c]) !== 1'b0) begin
         @(negedge CLK);
         #1;
      end
      @(negedge CLK);
   endtask

   task automatic data_write(input int c, input addr_t a, input word_t w, input logic inv);
      daddr[c]   = a;
      dstore[c]  = w;
      ccwrite[c] = inv;                // invalidate the other copy
      dWEN[c]    = 1'b1;
      wait_done(1'b0, c);
      dWEN[c]    = 1'b0;
      ccwrite[c] = 1'b0;
      cctrans[c] = 1'b1;               // close the transaction
      @(negedge CLK);
      cctrans[c] = 1'b0;
   endtask

   task automatic data_read(input int c, input addr_t a);
      daddr[c]   = a;
      dREN[c]    = 1'b1;
      wait_done(1'b0, c);
      dREN[c]    = 1'b0;
      cctrans[c] = 1'b1;
      @(negedge CLK);
      cctrans[c] = 1'b0;
   endtask

   // core 1 owns the line modified, core 0 reads it
   task automatic cache_transfer(input addr_t a, input word_t w);
      daddr      = {a, a};
      dstore[1]  = w;
      ccwrite[1] = 1'b1;
      dWEN[1]    = 1'b1;
      dREN[0]    = 1'b1;
      wait_done(1'b0, 0);              // requester served straight from the owner
      dREN[0]    = 1'b0;
      wait_done(1'b0, 1);              // owner waits for the write back
      dWEN[1]    = 1'b0;
      ccwrite[1] = 1'b0;
      @(negedge CLK);                  // back to idle
   endtask

   task automatic end_test(input string name, input int mark);
      tests_run++;
      if (errors == mark) begin
         $display("%-24s ok", name);
      end else begin
         tests_failed++;
         $display("%-24s %0d errors", name, errors - mark);
      end
   endtask

   initial begin
      addr_t wr_addr [N_WR];
      addr_t a;
      int mark;
      {iREN, dREN, dWEN, ccwrite, cctrans} = '0;
      iaddr  = '0;
      daddr  = '0;
      dstore = '0;
      rng    = 32'd38860;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      @(posedge nRST);
      @(negedge CLK);
      @(negedge CLK);
      end_test("reset values", 0);

      mark = errors;
      for (int i = 0; i < N_WR; i++) begin
         rng = xorshift32(rng);
         a = addr_t'(rng);
         wr_addr[i] = a;
         rng = xorshift32(rng);
         data_write(i % 2, a, rng, 1'b0);
      end
      for (int i = 0; i < N_WR; i++) data_read(1 - i % 2, wr_addr[i]);  // other core reads
      end_test("ram write and read", mark);

      mark = errors;
      iaddr   = {wr_addr[1], wr_addr[0]};
      iREN    = '1;                    // both fetch at once
      wait_done(1'b1, 0);
      iREN[0] = 1'b0;
      wait_done(1'b1, 1);
      iREN[1] = 1'b0;
      end_test("fetch priority", mark);

      mark = errors;
      data_read(0, wr_addr[2]);
      repeat (3) @(negedge CLK);       // snoop address must hold while idle
      end_test("snoop signalling", mark);

      mark = errors;
      rng = xorshift32(rng);
      data_write(0, wr_addr[3], rng, 1'b1);
      data_read(0, wr_addr[3]);        // plain read, no invalidate
      end_test("invalidation", mark);

      mark = errors;
      rng = xorshift32(rng);
      cache_transfer(wr_addr[4], rng);
      data_read(1, wr_addr[4]);        // write back must be in ram
      end_test("cache to cache", mark);

      $display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin
      repeat (WD_CYCLES) @(posedge CLK);
      $display("timeout after %0d cycles, a wait signal never dropped", WD_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- memory_subsystem.f
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/cache_control_if.sv
rtl/ram_if.sv
rtl/memory_control.sv
rtl/ram.sv
rtl/memory_subsystem.sv
test/tb_clock.sv
test/tb_memory_subsystem.sv
